// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
TOP       ?= soc_mem_power_monitor_tb
FILELIST  ?= soc_mem_power_monitor.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "All tests passed!" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: common/mem_obs_pkg.sv
`default_nettype none

// ---------------------------------------------------------------------------
// Observed pins of the monitored memory ports
// ---------------------------------------------------------------------------

package mem_obs_pkg;

  // Handshake pins of the AXI slave port
  // Only valid/ready pairs matter for activity accounting
  typedef struct packed {
    logic aw_valid;
    logic aw_ready;
    logic w_valid;
    logic w_ready;
    logic ar_valid;
    logic ar_ready;
    logic r_valid;
    logic r_ready;
  } axi_obs_t;

  // Embedded MRAM control pins
  // An access starts when cs and one enable are both high
  typedef struct packed {
    logic cs;
    logic we_en;
    logic rd_en;
  } mram_pins_t;

endpackage

`default_nettype wire

// File: common/pwr_mon_config.svh
`ifndef PWR_MON_CONFIG_SVH
`define PWR_MON_CONFIG_SVH

// ---------------------------------------------------------------------------
// Datapath widths
// ---------------------------------------------------------------------------

// Every activity and operation counter
`define PWR_CNT_W 32
// Every energy accumulator and report energy
`define PWR_E_W 48

// ---------------------------------------------------------------------------
// Memory-side energy units charged per counted cycle
// ---------------------------------------------------------------------------

// Static share, charged on every powered cycle
`define PWR_W_LEAK 1
// Idle bus with the domain powered
`define PWR_W_BG 20
// Read beat on R channel
`define PWR_W_RD 110
// Write beat on W channel
`define PWR_W_WR 125

// ---------------------------------------------------------------------------
// MRAM energy units per cycle and charged cycles per operation
// ---------------------------------------------------------------------------

`define PWR_W_MLEAK 0
`define PWR_W_MRD 10
`define PWR_W_MWR 20

// Pin-level abstraction of one MRAM access
`define MRAM_RD_CYCLES 2
`define MRAM_WR_CYCLES 100

`endif

// File: common/pwr_report_pkg.sv
`default_nettype none

`include "pwr_mon_config.svh"

// ---------------------------------------------------------------------------
// Counter sets, report layout and reporter control types
// ---------------------------------------------------------------------------

package pwr_report_pkg;

  typedef logic [`PWR_CNT_W-1:0] pwr_cnt_t;
  typedef logic [`PWR_E_W-1:0]   pwr_energy_t;

  // AXI side activity, all in clock cycles or handshakes
  typedef struct packed {
    pwr_cnt_t cycles_total;
    pwr_cnt_t cycles_on;
    pwr_cnt_t cycles_bg;
    pwr_cnt_t cycles_rd;
    pwr_cnt_t cycles_wr;
    pwr_cnt_t aw_cnt;
    pwr_cnt_t ar_cnt;
  } axi_counts_t;

  // MRAM side, operations and the cycles charged for them
  typedef struct packed {
    pwr_cnt_t rd_ops;
    pwr_cnt_t wr_ops;
    pwr_cnt_t rd_cycles;
    pwr_cnt_t wr_cycles;
  } mram_counts_t;

  // Full report as seen by the requester
  typedef struct packed {
    axi_counts_t  axi;
    mram_counts_t mram;
    pwr_energy_t  e_ddr;
    pwr_energy_t  e_mram;
    pwr_energy_t  e_total;
  } pwr_report_t;

  // Reporter FSM
  typedef enum logic [1:0] {
    RPT_IDLE = 2'd0,
    RPT_SNAP = 2'd1,
    RPT_MAC  = 2'd2,
    RPT_DONE = 2'd3
  } rpt_state_e;

  // MAC opcodes, stepped in order
  // First four land in e_ddr, last three in e_mram
  typedef enum logic [2:0] {
    TERM_ON    = 3'd0,
    TERM_BG    = 3'd1,
    TERM_RD    = 3'd2,
    TERM_WR    = 3'd3,
    TERM_MLEAK = 3'd4,
    TERM_MRD   = 3'd5,
    TERM_MWR   = 3'd6
  } mac_term_e;

endpackage

`default_nettype wire

// File: design/mem_activity_counter.sv
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// AXI activity counters of the monitored memory domain
// ---------------------------------------------------------------------------

module mem_activity_counter
  import mem_obs_pkg::*;
  import pwr_report_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_mem_pwr_on,
  input  axi_obs_t    i_axi,
  input  logic        i_clear,
  output axi_counts_t o_counts
);

  // Beat and address handshakes seen this cycle
  logic rd_xfer;
  logic wr_xfer;
  logic aw_hs;
  logic ar_hs;

  axi_counts_t counts_q;

  assign rd_xfer = i_axi.r_valid & i_axi.r_ready;
  assign wr_xfer = i_axi.w_valid & i_axi.w_ready;
  assign aw_hs   = i_axi.aw_valid & i_axi.aw_ready;
  assign ar_hs   = i_axi.ar_valid & i_axi.ar_ready;

  // ------------------------------------------------------------------------
  // Counter update
  // ------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      counts_q <= '0;
    end else if (i_clear) begin
      // Clear edge counts nothing of its own cycle
      counts_q <= '0;
    end else begin
      // Wall clock runs regardless of power state
      counts_q.cycles_total <= counts_q.cycles_total + 1'b1;

      if (i_mem_pwr_on) begin
        counts_q.cycles_on <= counts_q.cycles_on + 1'b1;

        // Read and write beats are independent buckets
        if (rd_xfer) begin
          counts_q.cycles_rd <= counts_q.cycles_rd + 1'b1;
        end
        if (wr_xfer) begin
          counts_q.cycles_wr <= counts_q.cycles_wr + 1'b1;
        end

        // Background only when no beat moves at all
        if (!rd_xfer && !wr_xfer) begin
          counts_q.cycles_bg <= counts_q.cycles_bg + 1'b1;
        end

        // Accepted address phases
        if (aw_hs) begin
          counts_q.aw_cnt <= counts_q.aw_cnt + 1'b1;
        end
        if (ar_hs) begin
          counts_q.ar_cnt <= counts_q.ar_cnt + 1'b1;
        end
      end
    end
  end

  assign o_counts = counts_q;

endmodule

`default_nettype wire

// File: design/mram_op_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwr_mon_config.svh"

// ---------------------------------------------------------------------------
// MRAM operation counter, edge based on cs with enable
// ---------------------------------------------------------------------------

module mram_op_counter
  import mem_obs_pkg::*;
  import pwr_report_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  logic         i_mem_pwr_on,
  input  mram_pins_t   i_mram,
  input  logic         i_clear,
  output mram_counts_t o_counts
);

  // Access conditions this cycle and last cycle
  logic wr_cond;
  logic rd_cond;
  logic wr_cond_q;
  logic rd_cond_q;

  // One pulse per access, a held enable counts once
  logic wr_fire;
  logic rd_fire;

  mram_counts_t counts_q;

  assign wr_cond = i_mram.cs & i_mram.we_en;
  assign rd_cond = i_mram.cs & i_mram.rd_en;
  assign wr_fire = i_mem_pwr_on & wr_cond & ~wr_cond_q;
  assign rd_fire = i_mem_pwr_on & rd_cond & ~rd_cond_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_cond_q <= 1'b0;
      rd_cond_q <= 1'b0;
      counts_q  <= '0;
    end else if (i_clear) begin
      // History restarts too
      wr_cond_q <= 1'b0;
      rd_cond_q <= 1'b0;
      counts_q  <= '0;
    end else begin
      // History tracks even while powered off
      wr_cond_q <= wr_cond;
      rd_cond_q <= rd_cond;

      if (wr_fire) begin
        counts_q.wr_ops    <= counts_q.wr_ops + 1'b1;
        counts_q.wr_cycles <= counts_q.wr_cycles + `PWR_CNT_W'(`MRAM_WR_CYCLES);
      end
      if (rd_fire) begin
        counts_q.rd_ops    <= counts_q.rd_ops + 1'b1;
        counts_q.rd_cycles <= counts_q.rd_cycles + `PWR_CNT_W'(`MRAM_RD_CYCLES);
      end
    end
  end

  assign o_counts = counts_q;

endmodule

`default_nettype wire

// File: design/soc_mem_power_monitor.sv
`timescale 1ns/1ps
`default_nettype none

// ---------------------------------------------------------------------------
// Memory power monitor top
// Activity counters feed the reporter, report latency nine cycles
// ---------------------------------------------------------------------------

module soc_mem_power_monitor
  import mem_obs_pkg::*;
  import pwr_report_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,
  input  logic        i_mem_pwr_on,
  input  axi_obs_t    i_axi,
  input  mram_pins_t  i_mram,
  input  logic        i_clear,
  input  logic        i_rpt_req,
  output logic        o_rpt_ack,
  output pwr_report_t o_report
);

  // Live counter sets
  axi_counts_t  axi_counts;
  mram_counts_t mram_counts;

  // AXI beat and handshake accounting
  mem_activity_counter u_mem_activity_counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mem_pwr_on (i_mem_pwr_on),
    .i_axi        (i_axi),
    .i_clear      (i_clear),
    .o_counts     (axi_counts)
  );

  // MRAM operations from pin edges
  mram_op_counter u_mram_op_counter (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mem_pwr_on (i_mem_pwr_on),
    .i_mram       (i_mram),
    .i_clear      (i_clear),
    .o_counts     (mram_counts)
  );

  // Clear does not reach the reporter, a report in flight stays intact
  energy_reporter u_energy_reporter (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_axi_counts  (axi_counts),
    .i_mram_counts (mram_counts),
    .i_rpt_req     (i_rpt_req),
    .o_rpt_ack     (o_rpt_ack),
    .o_report      (o_report)
  );

endmodule

`default_nettype wire

// File: dv/soc_mem_power_monitor_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwr_mon_config.svh"

module soc_mem_power_monitor_tb
  import mem_obs_pkg::*;
  import pwr_report_pkg::*;
();

  // Estimated length of all tests in cycles
  // The run is cut at ten times that
  localparam int TEST_CYCLES      = 530;
  localparam int TIMEOUT_CYCLES   = 10 * TEST_CYCLES;
  localparam int ACK_WAIT_LIMIT   = 20;
  // Req is sampled on the first edge after it is driven
  // Ack follows nine edges later
  localparam int REQ_TO_ACK_EDGES = 10;

  // MRAM pin patterns in cs, we_en, rd_en order
  localparam mram_pins_t MRAM_WR    = 3'b110;
  localparam mram_pins_t MRAM_RD    = 3'b101;
  localparam mram_pins_t MRAM_NO_CS = 3'b001;

  logic        clk;
  logic        rst_n;
  logic        i_mem_pwr_on;
  axi_obs_t    i_axi;
  mram_pins_t  i_mram;
  logic        i_clear;
  logic        i_rpt_req;
  logic        o_rpt_ack;
  pwr_report_t o_report;

  // Reference tallies of driven events since the last clear
  int unsigned t_rd;
  int unsigned t_wr;
  int unsigned t_aw;
  int unsigned t_ar;
  int unsigned t_beat;
  int unsigned t_mrd;
  int unsigned t_mwr;
  bit          prev_wcond;
  bit          prev_rcond;
  bit          pwr_state;

  logic [15:0] lfsr_state;
  int unsigned cycle_cnt;
  int unsigned check_cnt;
  int unsigned error_cnt;

  soc_mem_power_monitor uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_mem_pwr_on (i_mem_pwr_on),
    .i_axi        (i_axi),
    .i_mram       (i_mram),
    .i_clear      (i_clear),
    .i_rpt_req    (i_rpt_req),
    .o_rpt_ack    (o_rpt_ack),
    .o_report     (o_report)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Watchdog
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        $display("Error: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
      end
    end
  end

  // --------------------------------------------------------------------------
  // Random bits from a 16-bit Galois LFSR
  // --------------------------------------------------------------------------

  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  task automatic take_bits(input int n, output int unsigned v);
    v = 0;
    repeat (n) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = (v << 1) | {31'd0, lfsr_state[0]};
    end
  endtask

  // --------------------------------------------------------------------------
  // Checks and expected energies
  // --------------------------------------------------------------------------

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    check_cnt++;
    assert (got == exp) else begin
      error_cnt++;
      $display("Fail t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_report_equal(input string name, input pwr_report_t got,
                                    input pwr_report_t exp);
    check_cnt++;
    assert (got == exp) else begin
      error_cnt++;
      $display("Fail t=%0t %s got=%0h exp=%0h", $time, name, got, exp);
    end
  endtask

  task automatic check_true(input bit cond, input string msg);
    check_cnt++;
    assert (cond) else begin
      error_cnt++;
      $display("Error at %0t: %s", $time, msg);
    end
  endtask

  function automatic logic [63:0] expected_ddr(input pwr_report_t r);
    return 64'(r.axi.cycles_on) * `PWR_W_LEAK + 64'(r.axi.cycles_bg) * `PWR_W_BG
         + 64'(r.axi.cycles_rd) * `PWR_W_RD + 64'(r.axi.cycles_wr) * `PWR_W_WR;
  endfunction

  function automatic logic [63:0] expected_mram(input pwr_report_t r);
    return 64'(r.axi.cycles_on) * `PWR_W_MLEAK + 64'(r.mram.rd_cycles) * `PWR_W_MRD
         + 64'(r.mram.wr_cycles) * `PWR_W_MWR;
  endfunction

  task automatic check_report(input pwr_report_t r);
    check_value("cycles_rd", r.axi.cycles_rd, t_rd);
    check_value("cycles_wr", r.axi.cycles_wr, t_wr);
    check_value("aw_cnt", r.axi.aw_cnt, t_aw);
    check_value("ar_cnt", r.axi.ar_cnt, t_ar);
    check_value("rd_ops", r.mram.rd_ops, t_mrd);
    check_value("wr_ops", r.mram.wr_ops, t_mwr);
    check_value("rd_cycles", r.mram.rd_cycles, 64'(t_mrd) * `MRAM_RD_CYCLES);
    check_value("wr_cycles", r.mram.wr_cycles, 64'(t_mwr) * `MRAM_WR_CYCLES);
    // Every powered cycle is either background or carries a beat
    check_value("cycles_bg+beats", 64'(r.axi.cycles_bg) + t_beat, r.axi.cycles_on);
    check_value("e_ddr", r.e_ddr, expected_ddr(r));
    check_value("e_mram", r.e_mram, expected_mram(r));
    check_value("e_total", r.e_total, expected_ddr(r) + expected_mram(r));
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // Drives one cycle of pins and tallies them as the DUT samples them on the next edge
  task automatic drive_cycle(input axi_obs_t a, input mram_pins_t m);
    bit wcond;
    bit rcond;
    @(posedge clk);
    i_axi  <= a;
    i_mram <= m;
    wcond = m.cs & m.we_en;
    rcond = m.cs & m.rd_en;
    if (pwr_state) begin
      t_rd   += (a.r_valid & a.r_ready);
      t_wr   += (a.w_valid & a.w_ready);
      t_beat += ((a.r_valid & a.r_ready) | (a.w_valid & a.w_ready));
      t_aw   += (a.aw_valid & a.aw_ready);
      t_ar   += (a.ar_valid & a.ar_ready);
      t_mwr  += (wcond & ~prev_wcond);
      t_mrd  += (rcond & ~prev_rcond);
    end
    prev_wcond = wcond;
    prev_rcond = rcond;
  endtask

  // Pins hold across this edge while the AXI side stays idle
  task automatic set_power(input bit on);
    @(posedge clk);
    i_mem_pwr_on <= on;
    pwr_state = on;
  endtask

  task automatic reset_tallies();
    t_rd   = 0;
    t_wr   = 0;
    t_aw   = 0;
    t_ar   = 0;
    t_beat = 0;
    t_mrd  = 0;
    t_mwr  = 0;
  endtask

  task automatic pulse_clear();
    drive_cycle('0, '0);
    i_clear <= 1'b1;
    @(posedge clk);
    i_clear <= 1'b0;
    reset_tallies();
  endtask

  task automatic drive_axi_bursts(input int n_bursts);
    int unsigned len;
    int unsigned bits;
    int unsigned gap;
    for (int b = 0; b < n_bursts; b++) begin
      take_bits(3, len);
      for (int i = 0; i <= int'(len); i++) begin
        take_bits(8, bits);
        drive_cycle(bits[7:0], '0);
      end
      take_bits(2, gap);
      repeat (gap) drive_cycle('0, '0);
    end
    drive_cycle('0, '0);
  endtask

  task automatic drive_mram_pulses(input int n_wr, input int n_rd);
    int unsigned len;
    int unsigned gap;
    // Each long write enable is one access
    repeat (n_wr) begin
      take_bits(3, len);
      repeat (len + 2) drive_cycle('0, MRAM_WR);
      drive_cycle('0, '0);
    end
    // Short reads and then an enable without cs that must not count
    repeat (n_rd) begin
      take_bits(1, len);
      repeat (len + 1) drive_cycle('0, MRAM_RD);
      take_bits(1, gap);
      repeat (gap + 1) drive_cycle('0, '0);
    end
    drive_cycle('0, MRAM_NO_CS);
    drive_cycle('0, '0);
  endtask

  // Full four-phase handshake with an optional clear mid-report and traffic while held
  task automatic run_report(input bit clear_mid, input int hold_cycles,
                            output pwr_report_t rep);
    int          edges;
    bit          ack_seen;
    int unsigned bits;
    check_true(!o_rpt_ack, "ack high before a request");
    drive_cycle('0, '0);
    i_rpt_req <= 1'b1;
    edges    = 0;
    ack_seen = 1'b0;
    while (!ack_seen && edges < ACK_WAIT_LIMIT) begin
      @(posedge clk);
      edges++;
      // Lands after the snapshot edge
      i_clear <= clear_mid && (edges == 2);
      @(negedge clk);
      ack_seen = o_rpt_ack;
    end
    check_true(ack_seen, "ack did not rise within the wait limit");
    check_value("req_to_ack_edges", edges, REQ_TO_ACK_EDGES);
    rep = o_report;
    for (int h = 0; h < hold_cycles; h++) begin
      take_bits(8, bits);
      drive_cycle(bits[7:0], '0);
      @(negedge clk);
      check_true(o_rpt_ack, "ack dropped while req was still held");
      check_report_equal("o_report", o_report, rep);
    end
    drive_cycle('0, '0);
    i_rpt_req <= 1'b0;
    @(negedge clk);
    check_true(o_rpt_ack, "ack fell before req low was sampled");
    @(negedge clk);
    check_true(!o_rpt_ack, "ack did not fall one cycle after req dropped");
  endtask

  // --------------------------------------------------------------------------
  // Tests
  // --------------------------------------------------------------------------

  task automatic test_reset_idle();
    pwr_report_t rep;
    @(negedge clk);
    check_value("o_rpt_ack", o_rpt_ack, 0);
    check_report_equal("o_report", o_report, '0);
    repeat (5) drive_cycle('0, '0);
    run_report(1'b0, 0, rep);
    check_report(rep);
  endtask

  task automatic test_axi_traffic();
    pwr_report_t rep;
    drive_axi_bursts(12);
    run_report(1'b0, 0, rep);
    check_report(rep);
  endtask

  task automatic test_mram_edges();
    pwr_report_t rep;
    drive_mram_pulses(2, 3);
    run_report(1'b0, 0, rep);
    check_report(rep);
  endtask

  task automatic test_power_gating();
    pwr_report_t rep_a;
    pwr_report_t rep_b;
    pwr_report_t rep_c;
    set_power(1'b0);
    run_report(1'b0, 0, rep_a);
    drive_axi_bursts(4);
    drive_mram_pulses(1, 2);
    run_report(1'b0, 0, rep_b);
    check_report(rep_b);
    check_value("cycles_on", rep_b.axi.cycles_on, rep_a.axi.cycles_on);
    check_value("cycles_rd", rep_b.axi.cycles_rd, rep_a.axi.cycles_rd);
    check_value("wr_ops", rep_b.mram.wr_ops, rep_a.mram.wr_ops);
    check_true(rep_b.axi.cycles_total > rep_a.axi.cycles_total,
               "cycles_total did not advance while powered off");
    // Enable raised while off and still held after power-on
    repeat (3) drive_cycle('0, MRAM_WR);
    set_power(1'b1);
    repeat (2) drive_cycle('0, MRAM_WR);
    drive_cycle('0, '0);
    run_report(1'b0, 0, rep_c);
    check_report(rep_c);
    check_value("wr_ops", rep_c.mram.wr_ops, rep_b.mram.wr_ops);
  endtask

  task automatic test_clear();
    pwr_report_t rep;
    drive_axi_bursts(3);
    // Report in flight keeps the counts from before the clear
    run_report(1'b1, 0, rep);
    check_report(rep);
    reset_tallies();
    drive_axi_bursts(3);
    drive_mram_pulses(1, 1);
    pulse_clear();
    drive_axi_bursts(4);
    drive_mram_pulses(1, 2);
    run_report(1'b0, 0, rep);
    check_report(rep);
  endtask

  task automatic test_handshake();
    pwr_report_t rep;
    run_report(1'b0, 6, rep);
    run_report(1'b0, 0, rep);
    check_report(rep);
  endtask

  initial begin
    rst_n        = 1'b0;
    i_mem_pwr_on = 1'b1;
    i_axi        = '0;
    i_mram       = '0;
    i_clear      = 1'b0;
    i_rpt_req    = 1'b0;
    pwr_state    = 1'b1;
    prev_wcond   = 1'b0;
    prev_rcond   = 1'b0;
    lfsr_state   = 16'd59150;
    check_cnt    = 0;
    error_cnt    = 0;
    reset_tallies();
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;

    test_reset_idle();
    test_axi_traffic();
    test_mram_edges();
    test_power_gating();
    test_clear();
    test_handshake();

    $display("Summary: %0d checks, %0d errors", check_cnt, error_cnt);
    if (error_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: energy_report/energy_reporter.sv
`timescale 1ns/1ps
`default_nettype none

`include "pwr_mon_config.svh"

// ---------------------------------------------------------------------------
// Snapshot of live counters and weighted energy sum, one term per clock
// Four-phase req/ack toward the requester
// ---------------------------------------------------------------------------

module energy_reporter
  import pwr_report_pkg::*;
(
  input  logic         clk,
  input  logic         rst_n,
  input  axi_counts_t  i_axi_counts,
  input  mram_counts_t i_mram_counts,
  input  logic         i_rpt_req,
  output logic         o_rpt_ack,
  output pwr_report_t  o_report
);

  rpt_state_e state;
  mac_term_e  term;

  // Frozen copy, live counters keep running underneath
  axi_counts_t  snap_axi;
  mram_counts_t snap_mram;

  // Running energy sums
  pwr_energy_t e_ddr_acc;
  pwr_energy_t e_mram_acc;

  // Current MAC operands
  pwr_energy_t mac_operand;
  pwr_energy_t mac_weight;
  pwr_energy_t mac_product;
  logic        mac_to_mram;

  // ------------------------------------------------------------------------
  // Term select
  // ------------------------------------------------------------------------

  always_comb begin
    case (term)
      TERM_ON: begin
        mac_operand = `PWR_E_W'(snap_axi.cycles_on);
        mac_weight  = `PWR_E_W'(`PWR_W_LEAK);
      end
      TERM_BG: begin
        mac_operand = `PWR_E_W'(snap_axi.cycles_bg);
        mac_weight  = `PWR_E_W'(`PWR_W_BG);
      end
      TERM_RD: begin
        mac_operand = `PWR_E_W'(snap_axi.cycles_rd);
        mac_weight  = `PWR_E_W'(`PWR_W_RD);
      end
      TERM_WR: begin
        mac_operand = `PWR_E_W'(snap_axi.cycles_wr);
        mac_weight  = `PWR_E_W'(`PWR_W_WR);
      end
      // MRAM static share also follows powered cycles
      TERM_MLEAK: begin
        mac_operand = `PWR_E_W'(snap_axi.cycles_on);
        mac_weight  = `PWR_E_W'(`PWR_W_MLEAK);
      end
      TERM_MRD: begin
        mac_operand = `PWR_E_W'(snap_mram.rd_cycles);
        mac_weight  = `PWR_E_W'(`PWR_W_MRD);
      end
      TERM_MWR: begin
        mac_operand = `PWR_E_W'(snap_mram.wr_cycles);
        mac_weight  = `PWR_E_W'(`PWR_W_MWR);
      end
      default: begin
        mac_operand = '0;
        mac_weight  = '0;
      end
    endcase
  end

  assign mac_product = mac_operand * mac_weight;
  assign mac_to_mram = (term >= TERM_MLEAK);

  // ------------------------------------------------------------------------
  // Snapshot and accumulate
  // ------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (state == RPT_SNAP) begin
      snap_axi   <= i_axi_counts;
      snap_mram  <= i_mram_counts;
      e_ddr_acc  <= '0;
      e_mram_acc <= '0;
    end else if (state == RPT_MAC) begin
      if (mac_to_mram) begin
        e_mram_acc <= e_mram_acc + mac_product;
      end else begin
        e_ddr_acc <= e_ddr_acc + mac_product;
      end
    end
  end

  // ------------------------------------------------------------------------
  // Control FSM and report register
  // ------------------------------------------------------------------------

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state     <= RPT_IDLE;
      term      <= TERM_ON;
      o_rpt_ack <= 1'b0;
      o_report  <= '0;
    end else begin
      case (state)
        RPT_IDLE: begin
          if (i_rpt_req) begin
            state <= RPT_SNAP;
          end
        end
        RPT_SNAP: begin
          term  <= TERM_ON;
          state <= RPT_MAC;
        end
        RPT_MAC: begin
          // Seven edges, last one is TERM_MWR
          if (term == TERM_MWR) begin
            state <= RPT_DONE;
          end else begin
            term <= mac_term_e'(term + 3'd1);
          end
        end
        RPT_DONE: begin
          if (!o_rpt_ack) begin
            // Report and ack change on the same edge
            o_report.axi     <= snap_axi;
            o_report.mram    <= snap_mram;
            o_report.e_ddr   <= e_ddr_acc;
            o_report.e_mram  <= e_mram_acc;
            o_report.e_total <= e_ddr_acc + e_mram_acc;
            o_rpt_ack        <= 1'b1;
          end else if (!i_rpt_req) begin
            // Requester let go, finish the handshake
            o_rpt_ack <= 1'b0;
            state     <= RPT_IDLE;
          end
        end
        default: begin
          state <= RPT_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: soc_mem_power_monitor.f
+incdir+common
common/mem_obs_pkg.sv
common/pwr_report_pkg.sv
design/mem_activity_counter.sv
design/mram_op_counter.sv
energy_report/energy_reporter.sv
design/soc_mem_power_monitor.sv
dv/soc_mem_power_monitor_tb.sv
